// ==== src.f ====
+incdir+include
hw/trace_pkg.sv
hw/trace_ctrl.sv
hw/trace_timestamp.sv
hw/perf_event_counters.sv
hw/trace_stream_fifo.sv
hw/trace_monitor_top.sv
tb/trace_monitor_asserts.sv
tb/trace_monitor_tb.sv

// ==== tb/trace_monitor_tb.sv ====
////////////////////////////////////////////////////////////
// trace monitor testbench
// LFSR driven retire traffic checked against a cycle model
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_monitor_tb
    import trace_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                         clk;
    logic                         rst_n;
    logic                         en;
    logic                         pc_valid;
    logic [`TRACE_XLEN-1:0]       pc;
    logic [`TRACE_INSTR_W-1:0]    instr;
    logic [`TRACE_NUM_EVENTS-1:0] perf_events;
    logic                         ctrl_we;
    trace_ctrl_addr_t             ctrl_addr;
    logic [`TRACE_XLEN-1:0]       ctrl_wdata;
    logic [`TRACE_TLAST_W-1:0]    tlast_interval;
    logic                         m_tready;
    logic                         m_tvalid;
    logic [`TRACE_PKT_W-1:0]      m_tdata;
    logic                         m_tlast;

    logic [31:0] lfsr;
    // stall the sink / force every cycle valid
    logic        hold_ready;
    logic        always_valid;
    int          wait_cnt;

    // model of control registers and trigger state
    logic        mdl_start_en;
    logic        mdl_end_en;
    logic        mdl_low_en;
    logic        mdl_high_en;
    logic [31:0] mdl_start_addr;
    logic [31:0] mdl_end_addr;
    logic [31:0] mdl_low;
    logic [31:0] mdl_high;
    logic        mdl_started;
    logic        mdl_ended;
    logic [1:0]  mdl_stop;
    // model of datapath counters
    logic [15:0] mdl_cyc;
    logic [15:0] mdl_last_cap;
    logic [7:0]  mdl_run;
    logic [7:0]  mdl_evt [`TRACE_NUM_EVENTS];
    // expected packets whose count tracks the FIFO occupancy
    trace_pkt_u  exp_q [$];
    logic        tlast_q [$];

    trace_monitor_top i_dut (.*);

    bind trace_stream_fifo trace_monitor_asserts i_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .fifo_full (fifo_full),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast)
    );

    always #50 clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
        fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                           $time, what, got, exp));
    endtask

    task automatic drive_traffic(input logic [31:0] next_pc, input logic [31:0] next_instr);
        pc_valid    = always_valid || (rand_bits(2) != 32'd0);
        pc          = next_pc;
        instr       = next_instr;
        perf_events = 4'(rand_bits(4));
        m_tready    = !hold_ready && rand_bits(1);
    endtask

    // checks the beat and steps the model for one clock
    task automatic step();
        trace_pkt_u got;
        trace_pkt_u expd;
        logic       is_wfi;
        logic       cap;
        logic       tl;
        @(negedge clk);
        is_wfi = (instr == `TRACE_WFI_INSTR);
        // occupancy before this cycle's pop decides blocking
        cap = en && pc_valid && (exp_q.size() < `TRACE_FIFO_DEPTH) && (mdl_stop < 2'd2)
              && (!mdl_start_en || mdl_started) && (!mdl_end_en || !mdl_ended)
              && (!mdl_low_en || pc >= mdl_low) && (!mdl_high_en || pc <= mdl_high);
        assert (m_tvalid == (exp_q.size() != 0))
            else value_error("m_tvalid", m_tvalid, exp_q.size() != 0);
        if (m_tvalid && m_tready) begin
            got.bits = m_tdata;
            expd     = exp_q.pop_front();
            tl       = tlast_q.pop_front();
            assert (got.fields.pc == expd.fields.pc)
                else value_error("pc", got.fields.pc, expd.fields.pc);
            assert (got.fields.instr == expd.fields.instr)
                else value_error("instr", got.fields.instr, expd.fields.instr);
            assert (got.fields.delta == expd.fields.delta)
                else value_error("delta", got.fields.delta, expd.fields.delta);
            assert (got.fields.evt_counts == expd.fields.evt_counts)
                else value_error("evt_counts", got.fields.evt_counts, expd.fields.evt_counts);
            assert (m_tlast == tl) else value_error("m_tlast", m_tlast, tl);
        end
        if (cap) begin
            expd.fields.instr      = instr;
            expd.fields.delta      = mdl_cyc - mdl_last_cap;
            expd.fields.pc         = pc;
            expd.fields.evt_counts = {mdl_evt[3], mdl_evt[2], mdl_evt[1], mdl_evt[0]};
            tl = is_wfi || ((tlast_interval != '0) && (mdl_run + 8'd1 == tlast_interval));
            exp_q.push_back(expd);
            tlast_q.push_back(tl);
            mdl_run      = tl ? 8'd0 : mdl_run + 8'd1;
            mdl_last_cap = mdl_cyc;
        end
        mdl_cyc = mdl_cyc + 16'd1;
        for (int i = 0; i < `TRACE_NUM_EVENTS; i++) begin
            if (cap) begin
                mdl_evt[i] = 8'd0;
            end else if (perf_events[i] && mdl_evt[i] != 8'hff) begin
                mdl_evt[i] = mdl_evt[i] + 8'd1;
            end
        end
        if (is_wfi && en && mdl_stop < 2'd2) begin
            mdl_stop = mdl_stop + 2'd1;
        end else if (!is_wfi) begin
            mdl_stop = 2'd0;
        end
        if (ctrl_we) begin
            case (ctrl_addr)
                ADDR_START_EN:   mdl_start_en   = ctrl_wdata[0];
                ADDR_END_EN:     mdl_end_en     = ctrl_wdata[0];
                ADDR_START_ADDR: mdl_start_addr = ctrl_wdata;
                ADDR_END_ADDR:   mdl_end_addr   = ctrl_wdata;
                ADDR_LOW_EN:     mdl_low_en     = ctrl_wdata[0];
                ADDR_HIGH_EN:    mdl_high_en    = ctrl_wdata[0];
                ADDR_LOW_BOUND:  mdl_low        = ctrl_wdata;
                ADDR_HIGH_BOUND: mdl_high       = ctrl_wdata;
                ADDR_WFI_STOP:   mdl_stop       = ctrl_wdata[1:0];
                default: ;
            endcase
        end else begin
            if (mdl_start_en && pc == mdl_start_addr) begin
                mdl_started = 1'b1;
                mdl_ended   = 1'b0;
            end
            if (mdl_end_en && pc == mdl_end_addr) begin
                mdl_ended   = 1'b1;
                mdl_started = 1'b0;
            end
        end
        @(posedge clk);
        #5;
    endtask

    // traffic cycles keep flowing through a write
    task automatic write_ctrl(input trace_ctrl_addr_t addr, input logic [31:0] data);
        ctrl_we    = 1'b1;
        ctrl_addr  = addr;
        ctrl_wdata = data;
        step();
        ctrl_we    = 1'b0;
    endtask

    task automatic run_random(input int cycles, input logic [31:0] base, input int bits,
                              input int shift, input bit wfi_mix);
        logic [31:0] next_instr;
        for (int i = 0; i < cycles; i++) begin
            next_instr = rand_bits(32);
            if (wfi_mix && rand_bits(3) == 32'd0) begin
                next_instr = `TRACE_WFI_INSTR;
            end
            drive_traffic(base + (rand_bits(bits) << shift), next_instr);
            step();
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        en             = 1'b0;
        pc_valid       = 1'b0;
        pc             = '0;
        instr          = '0;
        perf_events    = '0;
        ctrl_we        = 1'b0;
        ctrl_addr      = ADDR_START_EN;
        ctrl_wdata     = '0;
        tlast_interval = '0;
        m_tready       = 1'b0;
        lfsr           = 32'hb606;
        hold_ready     = 1'b0;
        always_valid   = 1'b0;
        // model starts from the reset state
        {mdl_start_en, mdl_end_en, mdl_low_en, mdl_high_en} = '0;
        {mdl_started, mdl_ended, mdl_stop, mdl_run} = '0;
        mdl_start_addr = '0;
        mdl_end_addr   = '1;
        mdl_low        = '0;
        mdl_high       = '1;
        mdl_cyc        = '0;
        mdl_last_cap   = '0;
        for (int i = 0; i < `TRACE_NUM_EVENTS; i++) begin
            mdl_evt[i] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        en    = 1'b1;

        // no filters and then a few cycles with tracing off
        run_random(40, 32'h8000_0000, 16, 2, 1'b0);
        en = 1'b0;
        run_random(5, 32'h8000_0000, 16, 2, 1'b0);
        en = 1'b1;

        // address range and then each bound removed in turn
        write_ctrl(ADDR_LOW_BOUND, 32'h1000);
        write_ctrl(ADDR_HIGH_BOUND, 32'h1fff);
        write_ctrl(ADDR_LOW_EN, 32'd1);
        write_ctrl(ADDR_HIGH_EN, 32'd1);
        run_random(30, 32'h800, 11, 2, 1'b0);
        write_ctrl(ADDR_HIGH_EN, 32'd0);
        run_random(20, 32'h800, 11, 2, 1'b0);
        write_ctrl(ADDR_LOW_EN, 32'd0);

        // start and end triggers with pc hopping over 0x100 0x180 0x200 0x280
        write_ctrl(ADDR_START_ADDR, 32'h100);
        write_ctrl(ADDR_END_ADDR, 32'h200);
        write_ctrl(ADDR_START_EN, 32'd1);
        write_ctrl(ADDR_END_EN, 32'd1);
        // start pc during a write must not arm the trigger
        drive_traffic(32'h100, rand_bits(32));
        write_ctrl(ADDR_LOW_EN, 32'd0);
        run_random(4, 32'h180, 0, 0, 1'b0);
        run_random(40, 32'h100, 2, 7, 1'b0);
        write_ctrl(ADDR_START_EN, 32'd0);
        write_ctrl(ADDR_END_EN, 32'd0);

        // wfi run stops after two packets until a wfi_stop write rearms it
        always_valid = 1'b1;
        for (int i = 0; i < 6; i++) begin
            drive_traffic(32'h3000, `TRACE_WFI_INSTR);
            step();
        end
        write_ctrl(ADDR_WFI_STOP, 32'd0);
        drive_traffic(32'h3000, `TRACE_WFI_INSTR);
        step();
        always_valid = 1'b0;
        run_random(10, 32'h3000, 8, 2, 1'b0);

        // tlast every third packet and then wfi tlast only
        tlast_interval = 8'd3;
        run_random(40, 32'h4000, 8, 2, 1'b1);
        tlast_interval = 8'd0;
        run_random(20, 32'h4000, 8, 2, 1'b1);

        // stall the sink until the FIFO fills
        hold_ready   = 1'b1;
        always_valid = 1'b1;
        wait_cnt     = 0;
        while (exp_q.size() < `TRACE_FIFO_DEPTH && wait_cnt < 20) begin
            run_random(1, 32'h5000, 8, 2, 1'b0);
            wait_cnt++;
        end
        if (exp_q.size() < `TRACE_FIFO_DEPTH) begin
            fail_run("FIFO did not fill while the sink was stalled");
        end
        // blocked cycles still count events
        run_random(6, 32'h5000, 8, 2, 1'b0);
        hold_ready   = 1'b0;
        always_valid = 1'b0;
        run_random(20, 32'h5000, 8, 2, 1'b0);

        // drain with the sink always ready
        pc_valid = 1'b0;
        m_tready = 1'b1;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 50) begin
            step();
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected packets never left the stream", exp_q.size()));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
`default_nettype wire

// ==== tb/trace_monitor_asserts.sv ====
////////////////////////////////////////////////////////////
// stream and FIFO protocol assertions
// bound into the trace packet FIFO
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_monitor_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    fifo_full,
    input logic                    m_tvalid,
    input logic                    m_tready,
    input logic [`TRACE_PKT_W-1:0] m_tdata,
    input logic                    m_tlast
);
    timeunit 1ns;
    timeprecision 1ps;

    // stalled beat keeps its data and tlast
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
        else $error("stream beat changed while m_tready was low");

    // a stalled full FIFO stays full and takes nothing
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full && !m_tready |=> fifo_full)
        else $error("packet pushed while the FIFO was full");

    // reset empties the FIFO
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !m_tvalid)
        else $error("m_tvalid high after a reset cycle");

endmodule
`default_nettype wire

// ==== hw/trace_monitor_top.sv ====
////////////////////////////////////////////////////////////
// trace monitor top level
// filters retired instructions into trace packets and
// streams them out through a small FIFO
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_monitor_top
    import trace_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          en,
    // core retire port
    input  logic                                          pc_valid,
    input  logic [`TRACE_XLEN-1:0]                        pc,
    input  logic [`TRACE_INSTR_W-1:0]                     instr,
    input  logic [`TRACE_NUM_EVENTS-1:0]                  perf_events,
    // control write port
    input  logic                                          ctrl_we,
    input  trace_ctrl_addr_t                              ctrl_addr,
    input  logic [`TRACE_XLEN-1:0]                        ctrl_wdata,
    input  logic [`TRACE_TLAST_W-1:0]                     tlast_interval,
    // stream output
    input  logic                                          m_tready,
    output logic                                          m_tvalid,
    output logic [`TRACE_PKT_W-1:0]                       m_tdata,
    output logic                                          m_tlast
);

    logic                                         capture;
    logic                                         is_wfi;
    logic                                         fifo_full;
    logic [`TRACE_DELTA_W-1:0]                    delta;
    logic [`TRACE_NUM_EVENTS*`TRACE_EVT_CNT_W-1:0] evt_counts;
    trace_pkt_u                                   pkt;

    // packet built from the current input cycle
    assign pkt.fields = '{instr: instr, delta: delta, pc: pc, evt_counts: evt_counts};

    trace_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .pc_valid   (pc_valid),
        .pc         (pc),
        .instr      (instr),
        .ctrl_we    (ctrl_we),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .fifo_full  (fifo_full),
        .capture    (capture),
        .is_wfi     (is_wfi)
    );

    trace_timestamp i_timestamp (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .delta   (delta)
    );

    perf_event_counters i_evt_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .perf_events (perf_events),
        .evt_counts  (evt_counts)
    );

    trace_stream_fifo i_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .capture        (capture),
        .is_wfi         (is_wfi),
        .pkt            (pkt),
        .tlast_interval (tlast_interval),
        .m_tready       (m_tready),
        .fifo_full      (fifo_full),
        .m_tvalid       (m_tvalid),
        .m_tdata        (m_tdata),
        .m_tlast        (m_tlast)
    );

endmodule
`default_nettype wire

// ==== hw/trace_stream_fifo.sv ====
////////////////////////////////////////////////////////////
// trace packet FIFO with stream output
// stores each packet with its tlast bit, which is set on
// wfi or at the end of a tlast_interval run
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_stream_fifo
    import trace_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      capture,
    input  logic                      is_wfi,
    input  trace_pkt_u                pkt,
    input  logic [`TRACE_TLAST_W-1:0] tlast_interval,
    input  logic                      m_tready,
    output logic                      fifo_full,
    output logic                      m_tvalid,
    output logic [`TRACE_PKT_W-1:0]   m_tdata,
    output logic                      m_tlast
);

    localparam int DEPTH = `TRACE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

    // packet storage and matching tlast bits
    logic [`TRACE_PKT_W-1:0]   mem       [DEPTH];
    logic                      tlast_mem [DEPTH];

    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    // packets since the last tlast
    logic [`TRACE_TLAST_W-1:0] run_cnt;

    logic                      push;
    logic                      pop;
    logic                      pkt_tlast;

    assign fifo_full = (count == FULL_CNT);
    assign m_tvalid  = (count != '0);
    assign m_tdata   = mem[rd_ptr];
    assign m_tlast   = tlast_mem[rd_ptr];

    // full is sampled before this cycle's pop
    assign push = capture && !fifo_full;
    assign pop  = m_tvalid && m_tready;

    // interval of zero turns run counting off
    assign pkt_tlast = is_wfi
                       || ((tlast_interval != '0) && ((run_cnt + 1'b1) == tlast_interval));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr]       <= pkt.bits;
            tlast_mem[wr_ptr] <= pkt_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            run_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr  <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
                // restart the run after any tlast packet
                run_cnt <= pkt_tlast ? '0 : run_cnt + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
`default_nettype wire

// ==== hw/perf_event_counters.sv ====
////////////////////////////////////////////////////////////
// performance event counters
// one saturating count per event, cleared on capture
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module perf_event_counters (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           capture,
    input  logic [`TRACE_NUM_EVENTS-1:0]                   perf_events,
    output logic [`TRACE_NUM_EVENTS*`TRACE_EVT_CNT_W-1:0]  evt_counts
);

    genvar i;

    for (i = 0; i < `TRACE_NUM_EVENTS; i++) begin : g_evt
        logic [`TRACE_EVT_CNT_W-1:0] cnt;

        always_ff @(posedge clk) begin
            // events in the capture cycle are dropped
            if (!rst_n || capture) begin
                cnt <= '0;
            end else if (perf_events[i] && (cnt != '1)) begin
                cnt <= cnt + 1'b1;
            end
        end

        // event i in byte lane i
        assign evt_counts[i*`TRACE_EVT_CNT_W +: `TRACE_EVT_CNT_W] = cnt;
    end

endmodule
`default_nettype wire

// ==== hw/trace_timestamp.sv ====
////////////////////////////////////////////////////////////
// trace timestamp
// cycle counter and cycles since the previous capture
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_timestamp (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      capture,
    output logic [`TRACE_DELTA_W-1:0] delta
);

    // free running, wraps
    logic [`TRACE_DELTA_W-1:0] cycle_cnt;
    // counter value at the previous capture
    logic [`TRACE_DELTA_W-1:0] last_cap;

    assign delta = cycle_cnt - last_cap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            last_cap  <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (capture) begin
                last_cap <= cycle_cnt;
            end
        end
    end

endmodule
`default_nettype wire

// ==== hw/trace_ctrl.sv ====
////////////////////////////////////////////////////////////
// trace control block
// control registers, start/end triggers, wfi stop and
// the per-cycle capture decision
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

module trace_ctrl
    import trace_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      en,
    input  logic                      pc_valid,
    input  logic [`TRACE_XLEN-1:0]    pc,
    input  logic [`TRACE_INSTR_W-1:0] instr,
    input  logic                      ctrl_we,
    input  trace_ctrl_addr_t          ctrl_addr,
    input  logic [`TRACE_XLEN-1:0]    ctrl_wdata,
    input  logic                      fifo_full,
    output logic                      capture,
    output logic                      is_wfi
);

    // trigger registers
    logic                   start_en;
    logic                   end_en;
    logic [`TRACE_XLEN-1:0] start_addr;
    logic [`TRACE_XLEN-1:0] end_addr;
    // monitored range registers
    logic                   low_en;
    logic                   high_en;
    logic [`TRACE_XLEN-1:0] low_bound;
    logic [`TRACE_XLEN-1:0] high_bound;
    // trigger state
    logic                   started;
    logic                   ended;
    // saturates at 2, which blocks capture
    logic [1:0]             stop_cnt;

    logic                   start_hit;
    logic                   end_hit;
    logic                   range_ok;
    logic                   trig_ok;

    assign is_wfi    = (instr == `TRACE_WFI_INSTR);
    assign start_hit = start_en && (pc == start_addr);
    assign end_hit   = end_en && (pc == end_addr);

    // either bound can be switched off on its own
    assign range_ok = (!low_en || (pc >= low_bound)) && (!high_en || (pc <= high_bound));
    assign trig_ok  = (!start_en || started) && (!end_en || !ended);

    // held low during reset
    assign capture = rst_n && en && pc_valid && !fifo_full && (stop_cnt < 2'd2)
                     && trig_ok && range_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_en   <= 1'b0;
            end_en     <= 1'b0;
            start_addr <= '0;
            end_addr   <= '1;
            low_en     <= 1'b0;
            high_en    <= 1'b0;
            low_bound  <= '0;
            high_bound <= '1;
            started    <= 1'b0;
            ended      <= 1'b0;
            stop_cnt   <= 2'd0;
        end else begin
            // count consecutive wfi cycles
            if (is_wfi && en && (stop_cnt < 2'd2)) begin
                stop_cnt <= stop_cnt + 2'd1;
            end else if (!is_wfi) begin
                stop_cnt <= 2'd0;
            end

            if (ctrl_we) begin
                // register write, wfi_stop write overrides the count above
                case (ctrl_addr)
                    ADDR_START_EN:   start_en   <= ctrl_wdata[0];
                    ADDR_END_EN:     end_en     <= ctrl_wdata[0];
                    ADDR_START_ADDR: start_addr <= ctrl_wdata;
                    ADDR_END_ADDR:   end_addr   <= ctrl_wdata;
                    ADDR_LOW_EN:     low_en     <= ctrl_wdata[0];
                    ADDR_HIGH_EN:    high_en    <= ctrl_wdata[0];
                    ADDR_LOW_BOUND:  low_bound  <= ctrl_wdata;
                    ADDR_HIGH_BOUND: high_bound <= ctrl_wdata;
                    ADDR_WFI_STOP:   stop_cnt   <= ctrl_wdata[1:0];
                    default: ;
                endcase
            end else begin
                // no trigger matching during a write
                if (start_hit) begin
                    started <= 1'b1;
                    ended   <= 1'b0;
                end
                // end match wins if both hit
                if (end_hit) begin
                    ended   <= 1'b1;
                    started <= 1'b0;
                end
            end
        end
    end

endmodule
`default_nettype wire

// ==== hw/trace_pkg.sv ====
////////////////////////////////////////////////////////////
// trace monitor types
// control register map and the packet union
////////////////////////////////////////////////////////////
`default_nettype none
`include "trace_defs.svh"

package trace_pkg;

    // control register addresses
    typedef enum logic [`TRACE_CTRL_ADDR_W-1:0] {
        ADDR_START_EN   = 4'd0,
        ADDR_END_EN     = 4'd1,
        ADDR_START_ADDR = 4'd2,
        ADDR_END_ADDR   = 4'd3,
        ADDR_LOW_EN     = 4'd4,
        ADDR_HIGH_EN    = 4'd5,
        ADDR_LOW_BOUND  = 4'd6,
        ADDR_HIGH_BOUND = 4'd7,
        ADDR_WFI_STOP   = 4'd8
    } trace_ctrl_addr_t;

    // one trace packet, flat for storage or split into fields
    typedef union packed {
        logic [`TRACE_PKT_W-1:0] bits;
        struct packed {
            logic [`TRACE_INSTR_W-1:0]                      instr;
            logic [`TRACE_DELTA_W-1:0]                      delta;
            logic [`TRACE_XLEN-1:0]                         pc;
            // event 0 in the low byte
            logic [`TRACE_NUM_EVENTS*`TRACE_EVT_CNT_W-1:0]  evt_counts;
        } fields;
    } trace_pkt_u;

endpackage
`default_nettype wire

// ==== include/trace_defs.svh ====
////////////////////////////////////////////////////////////
// trace monitor shared widths and constants
// packet layout, FIFO depth and the wfi encoding
////////////////////////////////////////////////////////////
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// pc and address width
`define TRACE_XLEN 32
// instruction width
`define TRACE_INSTR_W 32
// cycle counter and packet delta field
`define TRACE_DELTA_W 16

// performance events, one counter each
`define TRACE_NUM_EVENTS 4
`define TRACE_EVT_CNT_W 8

// instr + delta + pc + four event counts
`define TRACE_PKT_W 112

// packet FIFO entries
`define TRACE_FIFO_DEPTH 4

// RISC-V wfi encoding
`define TRACE_WFI_INSTR 32'h1050_0073

// control port address and tlast run length widths
`define TRACE_CTRL_ADDR_W 4
`define TRACE_TLAST_W 8

`endif
